// ==== src/hci_ecc_enc.sv ====
/*
 * core-side ECC shim: encodes request data chunks and metadata,
 * corrects response data and opcode and reports the worst error class
 */

module hci_ecc_enc (
  // core side
  input  logic                                   req,
  output logic                                   gnt,
  input  logic [hci_ecc_pkg::ADDR_WIDTH-1:0]     add,
  input  logic                                   wen,
  input  logic [hci_ecc_pkg::BE_WIDTH-1:0]       be,
  input  logic [hci_ecc_pkg::DATA_WIDTH-1:0]     data,
  output logic                                   r_valid,
  output logic [hci_ecc_pkg::DATA_WIDTH-1:0]     r_data,
  output hci_ecc_pkg::resp_opc_e                 r_opc,
  output hci_ecc_pkg::ecc_err_e                  r_err,
  // bank side
  output logic                                   o_req,
  output logic [hci_ecc_pkg::ADDR_WIDTH-1:0]     o_add,
  output logic                                   o_wen,
  output logic [hci_ecc_pkg::BE_WIDTH-1:0]       o_be,
  output logic [hci_ecc_pkg::DATA_WIDTH-1:0]     o_data,
  output logic [hci_ecc_pkg::ECC_WIDTH-1:0]      o_ecc,
  input  logic                                   o_gnt,
  input  logic                                   o_r_valid,
  input  logic [hci_ecc_pkg::DATA_WIDTH-1:0]     o_r_data,
  input  hci_ecc_pkg::resp_opc_e                 o_r_opc,
  input  logic [hci_ecc_pkg::R_ECC_WIDTH-1:0]    o_r_ecc
);

  logic [hci_ecc_pkg::N_CHUNK-1:0][hci_ecc_pkg::CHUNK_SIZE-1:0] data_enc;
  logic [hci_ecc_pkg::N_CHUNK-1:0][hci_ecc_pkg::EW_DW-1:0]      data_ecc;
  logic [hci_ecc_pkg::RQMETAW-1:0]                              meta_enc;
  logic [hci_ecc_pkg::EW_RQMETA-1:0]                            meta_ecc;

  logic [hci_ecc_pkg::N_CHUNK-1:0][hci_ecc_pkg::CHUNK_SIZE-1:0] r_data_dec;
  logic [hci_ecc_pkg::N_CHUNK-1:0][hci_ecc_pkg::EW_DW-1:0]      r_data_ecc;
  hci_ecc_pkg::ecc_err_e                                        chunk_err [hci_ecc_pkg::N_CHUNK];
  hci_ecc_pkg::ecc_err_e                                        opc_err;
  logic [0:0]                                                   r_opc_dec;
  logic [1:0]                                                   err_any;

  // request side
  for (genvar i = 0; i < hci_ecc_pkg::N_CHUNK; i++) begin : g_data_enc
    hsiao_ecc_enc #(
      .DATA_W(hci_ecc_pkg::CHUNK_SIZE),
      .PROT_W(hci_ecc_pkg::EW_DW)
    ) u_data_enc (
      .in (data[i*hci_ecc_pkg::CHUNK_SIZE +: hci_ecc_pkg::CHUNK_SIZE]),
      .out({data_ecc[i], data_enc[i]})
    );
  end

  hsiao_ecc_enc #(
    .DATA_W(hci_ecc_pkg::RQMETAW),
    .PROT_W(hci_ecc_pkg::EW_RQMETA)
  ) u_meta_enc (
    .in ({add, wen, be}),
    .out({meta_ecc, meta_enc})
  );

  assign o_req  = req;
  assign gnt    = o_gnt;
  assign o_add  = meta_enc[hci_ecc_pkg::RQMETAW-1 -: hci_ecc_pkg::ADDR_WIDTH];
  assign o_wen  = meta_enc[hci_ecc_pkg::BE_WIDTH];
  assign o_be   = meta_enc[hci_ecc_pkg::BE_WIDTH-1:0];
  assign o_data = data_enc;
  assign o_ecc  = {data_ecc, meta_ecc};  // data checks on top, metadata checks low

  // response side
  assign r_data_ecc = o_r_ecc[hci_ecc_pkg::R_ECC_WIDTH-1:hci_ecc_pkg::EW_RSMETA];

  for (genvar i = 0; i < hci_ecc_pkg::N_CHUNK; i++) begin : g_data_dec
    hsiao_ecc_dec #(
      .DATA_W(hci_ecc_pkg::CHUNK_SIZE),
      .PROT_W(hci_ecc_pkg::EW_DW)
    ) u_data_dec (
      .in      ({r_data_ecc[i], o_r_data[i*hci_ecc_pkg::CHUNK_SIZE +: hci_ecc_pkg::CHUNK_SIZE]}),
      .out     (r_data_dec[i]),
      .syndrome(),
      .err     (chunk_err[i])
    );
  end

  hsiao_ecc_dec #(
    .DATA_W(1),
    .PROT_W(hci_ecc_pkg::EW_RSMETA)
  ) u_opc_dec (
    .in      ({o_r_ecc[hci_ecc_pkg::EW_RSMETA-1:0], o_r_opc}),
    .out     (r_opc_dec),
    .syndrome(),
    .err     (opc_err)
  );

  assign r_valid = o_r_valid;
  assign r_data  = r_data_dec;
  assign r_opc   = hci_ecc_pkg::resp_opc_e'(r_opc_dec);

  // worst class over all chunks and the opcode
  always_comb begin
    err_any = opc_err;
    for (int i = 0; i < hci_ecc_pkg::N_CHUNK; i++) begin
      err_any = err_any | chunk_err[i];
    end
    if (err_any[1]) r_err = hci_ecc_pkg::ECC_UNCORRECTABLE;
    else if (err_any[0]) r_err = hci_ecc_pkg::ECC_CORRECTED;
    else r_err = hci_ecc_pkg::ECC_OK;
  end

endmodule

// ==== src/hci_ecc_err_counter.sv ====
/*
 * saturating totals of corrected and uncorrectable ECC events
 */

module hci_ecc_err_counter (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                rsp_evt,
  input  hci_ecc_pkg::ecc_err_e               rsp_err,
  input  logic                                meta_evt,
  input  hci_ecc_pkg::ecc_err_e               meta_err,
  input  logic                                cnt_clear,
  output logic [hci_ecc_pkg::CNT_WIDTH-1:0]   cnt_corrected,
  output logic [hci_ecc_pkg::CNT_WIDTH-1:0]   cnt_uncorrectable
);

  logic [1:0] inc_corr;  // up to two events per cycle
  logic [1:0] inc_unc;

  function automatic logic [hci_ecc_pkg::CNT_WIDTH-1:0] sat_add(
    logic [hci_ecc_pkg::CNT_WIDTH-1:0] cnt,
    logic [1:0]                        inc
  );
    logic [hci_ecc_pkg::CNT_WIDTH:0] sum;
    sum = cnt + inc;
    sat_add = sum[hci_ecc_pkg::CNT_WIDTH] ? '1 : sum[hci_ecc_pkg::CNT_WIDTH-1:0];
  endfunction

  always_comb begin
    inc_corr = 2'(rsp_evt && rsp_err == hci_ecc_pkg::ECC_CORRECTED)
             + 2'(meta_evt && meta_err == hci_ecc_pkg::ECC_CORRECTED);
    inc_unc  = 2'(rsp_evt && rsp_err == hci_ecc_pkg::ECC_UNCORRECTABLE)
             + 2'(meta_evt && meta_err == hci_ecc_pkg::ECC_UNCORRECTABLE);
  end

  always_ff @(posedge clk) begin
    if (reset || cnt_clear) begin
      cnt_corrected     <= '0;
      cnt_uncorrectable <= '0;
    end else begin
      cnt_corrected     <= sat_add(cnt_corrected, inc_corr);
      cnt_uncorrectable <= sat_add(cnt_uncorrectable, inc_unc);
    end
  end

endmodule

// ==== src/hci_ecc_pkg.sv ====
/*
 * shared widths, code widths and enums of the ECC-protected TCDM path
 */

package hci_ecc_pkg;

  localparam int unsigned DATA_WIDTH  = 32;
  localparam int unsigned BE_WIDTH    = 4;
  localparam int unsigned ADDR_WIDTH  = 6;                 // 64-word bank
  localparam int unsigned CHUNK_SIZE  = 16;
  localparam int unsigned N_CHUNK     = DATA_WIDTH / CHUNK_SIZE;
  localparam int unsigned EW_DW       = $clog2(CHUNK_SIZE) + 2;
  localparam int unsigned RQMETAW     = ADDR_WIDTH + 1 + BE_WIDTH; // add, wen, be
  localparam int unsigned EW_RQMETA   = $clog2(RQMETAW) + 2;
  localparam int unsigned EW_RSMETA   = 3;                 // 1-bit opcode
  localparam int unsigned ECC_WIDTH   = N_CHUNK * EW_DW + EW_RQMETA;
  localparam int unsigned R_ECC_WIDTH = N_CHUNK * EW_DW + EW_RSMETA;
  localparam int unsigned CODE_WIDTH  = DATA_WIDTH + N_CHUNK * EW_DW; // stored word
  localparam int unsigned CNT_WIDTH   = 16;
  localparam int unsigned MAX_PROT    = 8;

  // bit 0 correctable, bit 1 uncorrectable
  typedef enum logic [1:0] {
    ECC_OK            = 2'b00,
    ECC_CORRECTED     = 2'b01,
    ECC_UNCORRECTABLE = 2'b10
  } ecc_err_e;

  typedef enum logic {
    OPC_OK       = 1'b0,
    OPC_META_ERR = 1'b1  // metadata uncorrectable, access dropped
  } resp_opc_e;

  // idx-th odd-weight column of weight 3 or more, lowest weight first
  function automatic logic [MAX_PROT-1:0] hsiao_col(int unsigned prot_w, int unsigned idx);
    int unsigned found;
    found = 0;
    hsiao_col = '0;
    for (int w = 3; w <= int'(prot_w); w += 2) begin
      for (int v = 0; v < (1 << prot_w); v++) begin
        if ($countones(v) == w) begin
          if (found == idx) hsiao_col = MAX_PROT'(v);
          found++;
        end
      end
    end
  endfunction

endpackage

// ==== src/hci_ecc_top.sv ====
/*
 * ECC-protected TCDM path: core shim, memory bank and error counters
 */

module hci_ecc_top (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   req,
  output logic                                   gnt,
  input  logic [hci_ecc_pkg::ADDR_WIDTH-1:0]     add,
  input  logic                                   wen,
  input  logic [hci_ecc_pkg::BE_WIDTH-1:0]       be,
  input  logic [hci_ecc_pkg::DATA_WIDTH-1:0]     data,
  output logic                                   r_valid,
  output logic [hci_ecc_pkg::DATA_WIDTH-1:0]     r_data,
  output hci_ecc_pkg::resp_opc_e                 r_opc,
  output hci_ecc_pkg::ecc_err_e                  r_err,
  input  logic                                   fault_en,
  input  logic [hci_ecc_pkg::ADDR_WIDTH-1:0]     fault_addr,
  input  logic [hci_ecc_pkg::CODE_WIDTH-1:0]     fault_mask,
  input  logic [hci_ecc_pkg::RQMETAW+hci_ecc_pkg::EW_RQMETA-1:0] link_mask,
  input  logic                                   cnt_clear,
  output logic [hci_ecc_pkg::CNT_WIDTH-1:0]      cnt_corrected,
  output logic [hci_ecc_pkg::CNT_WIDTH-1:0]      cnt_uncorrectable
);

  logic                                  bank_req;
  logic [hci_ecc_pkg::ADDR_WIDTH-1:0]    bank_add;
  logic                                  bank_wen;
  logic [hci_ecc_pkg::BE_WIDTH-1:0]      bank_be;
  logic [hci_ecc_pkg::DATA_WIDTH-1:0]    bank_data;
  logic [hci_ecc_pkg::ECC_WIDTH-1:0]     bank_ecc;
  logic                                  bank_gnt;
  logic                                  bank_r_valid;
  logic [hci_ecc_pkg::DATA_WIDTH-1:0]    bank_r_data;
  hci_ecc_pkg::resp_opc_e                bank_r_opc;
  logic [hci_ecc_pkg::R_ECC_WIDTH-1:0]   bank_r_ecc;
  logic                                  meta_evt;
  hci_ecc_pkg::ecc_err_e                 meta_err;

  hci_ecc_enc u_enc (
    .req      (req),          .gnt      (gnt),
    .add      (add),          .wen      (wen),
    .be       (be),           .data     (data),
    .r_valid  (r_valid),      .r_data   (r_data),
    .r_opc    (r_opc),        .r_err    (r_err),
    .o_req    (bank_req),     .o_add    (bank_add),
    .o_wen    (bank_wen),     .o_be     (bank_be),
    .o_data   (bank_data),    .o_ecc    (bank_ecc),
    .o_gnt    (bank_gnt),     .o_r_valid(bank_r_valid),
    .o_r_data (bank_r_data),  .o_r_opc  (bank_r_opc),
    .o_r_ecc  (bank_r_ecc)
  );

  tcdm_ecc_bank u_bank (
    .clk       (clk),         .reset     (reset),
    .req       (bank_req),    .add       (bank_add),
    .wen       (bank_wen),    .be        (bank_be),
    .data      (bank_data),   .ecc       (bank_ecc),
    .gnt       (bank_gnt),    .r_valid   (bank_r_valid),
    .r_data    (bank_r_data), .r_opc     (bank_r_opc),
    .r_ecc     (bank_r_ecc),  .fault_en  (fault_en),
    .fault_addr(fault_addr),  .fault_mask(fault_mask),
    .link_mask (link_mask),   .meta_evt  (meta_evt),
    .meta_err  (meta_err)
  );

  // response events come from the decoded core side
  hci_ecc_err_counter u_err_counter (
    .clk              (clk),
    .reset            (reset),
    .rsp_evt          (r_valid),
    .rsp_err          (r_err),
    .meta_evt         (meta_evt),
    .meta_err         (meta_err),
    .cnt_clear        (cnt_clear),
    .cnt_corrected    (cnt_corrected),
    .cnt_uncorrectable(cnt_uncorrectable)
  );

endmodule

// ==== src/hsiao_ecc_dec.sv ====
/*
 * hsiao SECDED decoder
 * syndrome, single-bit correction and error class
 */

module hsiao_ecc_dec #(
  parameter int unsigned DATA_W = hci_ecc_pkg::CHUNK_SIZE,
  parameter int unsigned PROT_W = hci_ecc_pkg::EW_DW
) (
  input  logic [PROT_W+DATA_W-1:0] in,
  output logic [DATA_W-1:0]        out,
  output logic [PROT_W-1:0]        syndrome,
  output hci_ecc_pkg::ecc_err_e    err
);

  logic [PROT_W-1:0] h_col [DATA_W];
  logic              hit;             // syndrome points at one bit

  for (genvar i = 0; i < DATA_W; i++) begin : g_col
    assign h_col[i] = PROT_W'(hci_ecc_pkg::hsiao_col(PROT_W, i));
  end

  // recomputed check bits against the received ones
  always_comb begin
    syndrome = in[DATA_W +: PROT_W];
    for (int i = 0; i < DATA_W; i++) begin
      if (in[i]) syndrome = syndrome ^ h_col[i];
    end
  end

  always_comb begin
    out = in[DATA_W-1:0];
    hit = 1'b0;
    for (int i = 0; i < DATA_W; i++) begin
      if (syndrome == h_col[i]) begin
        out[i] = ~out[i];
        hit    = 1'b1;
      end
    end
    // weight one means the flip sits in a check bit, data already good
    if ($countones(syndrome) == 1) hit = 1'b1;

    if (syndrome == '0) begin
      err = hci_ecc_pkg::ECC_OK;
    end else if (hit) begin
      err = hci_ecc_pkg::ECC_CORRECTED;
    end else begin
      err = hci_ecc_pkg::ECC_UNCORRECTABLE;  // even weight or unknown column
    end
  end

endmodule

// ==== src/hsiao_ecc_enc.sv ====
/*
 * hsiao SECDED encoder, systematic
 * output word is the check bits on top of the unchanged data
 */

module hsiao_ecc_enc #(
  parameter int unsigned DATA_W = hci_ecc_pkg::CHUNK_SIZE,
  parameter int unsigned PROT_W = hci_ecc_pkg::EW_DW
) (
  input  logic [DATA_W-1:0]        in,
  output logic [PROT_W+DATA_W-1:0] out
);

  logic [PROT_W-1:0] h_col [DATA_W];  // parity-check columns
  logic [PROT_W-1:0] check;

  for (genvar i = 0; i < DATA_W; i++) begin : g_col
    assign h_col[i] = PROT_W'(hci_ecc_pkg::hsiao_col(PROT_W, i));
  end

  // xor tree, one term per set data bit
  always_comb begin
    check = '0;
    for (int i = 0; i < DATA_W; i++) begin
      if (in[i]) check = check ^ h_col[i];
    end
  end

  assign out = {check, in};

endmodule

// ==== src/tcdm_ecc_bank.sv ====
/*
 * single-port TCDM bank: corrects request metadata, stores coded words,
 * answers one cycle after the grant, with storage and link fault injection
 */

module tcdm_ecc_bank (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   req,
  input  logic [hci_ecc_pkg::ADDR_WIDTH-1:0]     add,
  input  logic                                   wen,
  input  logic [hci_ecc_pkg::BE_WIDTH-1:0]       be,
  input  logic [hci_ecc_pkg::DATA_WIDTH-1:0]     data,
  input  logic [hci_ecc_pkg::ECC_WIDTH-1:0]      ecc,
  output logic                                   gnt,
  output logic                                   r_valid,
  output logic [hci_ecc_pkg::DATA_WIDTH-1:0]     r_data,
  output hci_ecc_pkg::resp_opc_e                 r_opc,
  output logic [hci_ecc_pkg::R_ECC_WIDTH-1:0]    r_ecc,
  input  logic                                   fault_en,
  input  logic [hci_ecc_pkg::ADDR_WIDTH-1:0]     fault_addr,
  input  logic [hci_ecc_pkg::CODE_WIDTH-1:0]     fault_mask,
  input  logic [hci_ecc_pkg::RQMETAW+hci_ecc_pkg::EW_RQMETA-1:0] link_mask,
  output logic                                   meta_evt,
  output hci_ecc_pkg::ecc_err_e                  meta_err
);

  logic [hci_ecc_pkg::CODE_WIDTH-1:0] mem [2**hci_ecc_pkg::ADDR_WIDTH];  // {checks, data}

  logic [hci_ecc_pkg::RQMETAW-1:0]     meta_fix;
  hci_ecc_pkg::ecc_err_e               meta_class;
  logic [hci_ecc_pkg::ADDR_WIDTH-1:0]  add_fix;
  logic                                wen_fix;
  logic [hci_ecc_pkg::BE_WIDTH-1:0]    be_fix;
  logic                                xfer;
  logic                                drop;
  logic                                wr_en;
  logic [hci_ecc_pkg::CODE_WIDTH-1:0]  wr_word;
  logic [hci_ecc_pkg::CODE_WIDTH-1:0]  rd_word;
  hci_ecc_pkg::resp_opc_e              opc_next;
  logic [hci_ecc_pkg::EW_RSMETA:0]     opc_code;  // {checks, opcode}

  // metadata as seen after the link
  hsiao_ecc_dec #(
    .DATA_W(hci_ecc_pkg::RQMETAW),
    .PROT_W(hci_ecc_pkg::EW_RQMETA)
  ) u_meta_dec (
    .in      ({ecc[hci_ecc_pkg::EW_RQMETA-1:0], add, wen, be} ^ link_mask),
    .out     (meta_fix),
    .syndrome(),
    .err     (meta_class)
  );

  assign {add_fix, wen_fix, be_fix} = meta_fix;

  assign gnt   = ~fault_en;  // port busy with the fault write
  assign xfer  = req & gnt;
  assign drop  = meta_class == hci_ecc_pkg::ECC_UNCORRECTABLE;
  assign wr_en = xfer & ~drop & ~wen_fix;  // wen low is a write

  // chunk lanes: a chunk is replaced only when all its bytes are enabled,
  // otherwise old data and old checks stay together
  always_comb begin
    wr_word = mem[add_fix];
    for (int c = 0; c < hci_ecc_pkg::N_CHUNK; c++) begin
      if (&be_fix[c*(hci_ecc_pkg::CHUNK_SIZE/8) +: hci_ecc_pkg::CHUNK_SIZE/8]) begin
        wr_word[c*hci_ecc_pkg::CHUNK_SIZE +: hci_ecc_pkg::CHUNK_SIZE] =
          data[c*hci_ecc_pkg::CHUNK_SIZE +: hci_ecc_pkg::CHUNK_SIZE];
        wr_word[hci_ecc_pkg::DATA_WIDTH + c*hci_ecc_pkg::EW_DW +: hci_ecc_pkg::EW_DW] =
          ecc[hci_ecc_pkg::EW_RQMETA + c*hci_ecc_pkg::EW_DW +: hci_ecc_pkg::EW_DW];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fault_en) mem[fault_addr] <= mem[fault_addr] ^ fault_mask;
    else if (wr_en) mem[add_fix] <= wr_word;
  end

  // writes and dropped requests answer with the all-zero codeword
  assign rd_word  = (xfer && !drop && wen_fix) ? mem[add_fix] : '0;
  assign opc_next = drop ? hci_ecc_pkg::OPC_META_ERR : hci_ecc_pkg::OPC_OK;

  hsiao_ecc_enc #(
    .DATA_W(1),
    .PROT_W(hci_ecc_pkg::EW_RSMETA)
  ) u_opc_enc (
    .in (opc_next),
    .out(opc_code)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      r_valid  <= 1'b0;
      meta_evt <= 1'b0;
    end else begin
      r_valid  <= xfer;
      meta_evt <= xfer & (meta_class != hci_ecc_pkg::ECC_OK);  // lines up with r_valid
    end
  end

  always_ff @(posedge clk) begin
    r_data   <= rd_word[hci_ecc_pkg::DATA_WIDTH-1:0];
    r_ecc    <= {rd_word[hci_ecc_pkg::CODE_WIDTH-1:hci_ecc_pkg::DATA_WIDTH],
                 opc_code[hci_ecc_pkg::EW_RSMETA:1]};
    r_opc    <= hci_ecc_pkg::resp_opc_e'(opc_code[0]);
    meta_err <= meta_class;
  end

endmodule

// ==== testbench/tb_hci_ecc_top.sv ====
/*
 * testbench for the ECC-protected TCDM path: random traffic, storage and
 * link faults, grant and counter control, checked against a reference model
 */

module tb_hci_ecc_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_CLEAN  = 200;
  localparam int N_SINGLE = 24;
  localparam int N_DOUBLE = 16;
  localparam int N_LINK   = 12;
  localparam int PLANNED  = N_CLEAN + 2 * N_SINGLE + 2 * N_DOUBLE + 5 * N_LINK + 2;
  localparam int TIMEOUT  = 20 * PLANNED + 100;
  localparam int CW       = hci_ecc_pkg::CODE_WIDTH;
  localparam int LW       = hci_ecc_pkg::RQMETAW + hci_ecc_pkg::EW_RQMETA;

  typedef struct packed {
    logic [hci_ecc_pkg::DATA_WIDTH-1:0] data;
    logic                               chk_data;
    hci_ecc_pkg::resp_opc_e             opc;
    hci_ecc_pkg::ecc_err_e              err;
    logic [1:0]                         corr;  // counter increments
    logic [1:0]                         unc;
    int                                 cyc;   // cycle of the grant
  } exp_t;

  logic clk, reset, req, gnt, wen, r_valid, fault_en, cnt_clear;
  logic [hci_ecc_pkg::ADDR_WIDTH-1:0] add, fault_addr;
  logic [hci_ecc_pkg::BE_WIDTH-1:0]   be;
  logic [hci_ecc_pkg::DATA_WIDTH-1:0] data, r_data;
  logic [CW-1:0]                      fault_mask;
  logic [LW-1:0]                      link_mask;
  hci_ecc_pkg::resp_opc_e             r_opc;
  hci_ecc_pkg::ecc_err_e              r_err;
  logic [hci_ecc_pkg::CNT_WIDTH-1:0]  cnt_corrected, cnt_uncorrectable;

  logic [hci_ecc_pkg::DATA_WIDTH-1:0] model_mem [64];
  logic [CW-1:0]                      model_fault [64];  // flips sitting in each word
  exp_t                               exp_q [$];
  logic [hci_ecc_pkg::CNT_WIDTH-1:0]  exp_corr = '0;
  logic [hci_ecc_pkg::CNT_WIDTH-1:0]  exp_unc = '0;
  integer seed;
  int cyc = 0;
  int errors = 0;
  int checks = 0;
  int rsp_cnt = 0;

  hci_ecc_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  function automatic int rand_below(input int n);
    rand_below = $unsigned($random(seed)) % n;
  endfunction

  // k-th bit of chunk c, data bits first, then its check bits
  function automatic int chunk_bit(input int c, input int k);
    if (k < hci_ecc_pkg::CHUNK_SIZE) chunk_bit = c * hci_ecc_pkg::CHUNK_SIZE + k;
    else chunk_bit = hci_ecc_pkg::DATA_WIDTH + c * hci_ecc_pkg::EW_DW
                     + k - hci_ecc_pkg::CHUNK_SIZE;
  endfunction

  // expected response of one granted request, updates the model memory
  function automatic exp_t predict(input logic w, input logic [5:0] a,
                                   input logic [31:0] d, input logic [LW-1:0] lm);
    exp_t e;
    int   worst;
    int   n;
    e = '0;
    e.opc = hci_ecc_pkg::OPC_OK;
    e.err = hci_ecc_pkg::ECC_OK;
    if ($countones(lm) >= 2) begin
      e.opc = hci_ecc_pkg::OPC_META_ERR;  // dropped, memory untouched
      e.unc = 2'd1;
    end else begin
      if ($countones(lm) == 1) e.corr = 2'd1;
      if (!w) begin
        model_mem[a] = d;
        model_fault[a] = '0;
      end else begin
        worst = 0;
        for (int c = 0; c < hci_ecc_pkg::N_CHUNK; c++) begin
          n = 0;
          for (int k = 0; k < hci_ecc_pkg::CHUNK_SIZE + hci_ecc_pkg::EW_DW; k++) begin
            n += model_fault[a][chunk_bit(c, k)];
          end
          if (n > worst) worst = n;
        end
        if (worst == 1) begin
          e.err = hci_ecc_pkg::ECC_CORRECTED;
          e.corr = e.corr + 2'd1;
        end else if (worst >= 2) begin
          e.err = hci_ecc_pkg::ECC_UNCORRECTABLE;
          e.unc = 2'd1;
        end
        e.data = model_mem[a];
        e.chk_data = worst < 2;
      end
    end
    predict = e;
  endfunction

  task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("error %s got %h exp %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_err(input hci_ecc_pkg::ecc_err_e got, input hci_ecc_pkg::ecc_err_e exp);
    checks++;
    if (got !== exp) begin
      $display("error r_err got %h exp %h", got, exp);
      errors++;
    end
  endtask

  task automatic check_opc(input hci_ecc_pkg::resp_opc_e got, input hci_ecc_pkg::resp_opc_e exp);
    checks++;
    if (got !== exp) begin
      $display("error r_opc got %h exp %h", got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      $display("error %s got %h exp %h", name, got, exp);
      errors++;
    end
  endtask

  // pops on each response, pushes on each grant
  always @(negedge clk) begin : compare
    exp_t e;
    if (!reset) begin
      if (r_valid) begin
        rsp_cnt++;
        if (exp_q.size() == 0) begin
          $display("response arrived with no outstanding request");
          errors++;
        end else begin
          e = exp_q.pop_front();
          check_count("cnt_corrected", cnt_corrected, exp_corr);
          check_count("cnt_uncorrectable", cnt_uncorrectable, exp_unc);
          if (e.cyc + 1 != cyc) begin
            $display("response came %0d cycles after its grant", cyc - e.cyc);
            errors++;
          end
          if (e.chk_data) check_data("r_data", r_data, e.data);
          check_opc(r_opc, e.opc);
          check_err(r_err, e.err);
          exp_corr += e.corr;
          exp_unc += e.unc;
        end
      end
      if (req && gnt) begin
        e = predict(wen, add, data, link_mask);
        e.cyc = cyc;
        exp_q.push_back(e);
      end
    end
  end

  task automatic issue(input logic w, input logic [5:0] a, input logic [31:0] d,
                       input logic [LW-1:0] lm);
    @(posedge clk);
    req <= 1'b1;
    wen <= w;
    add <= a;
    be <= 4'hf;  // full words only
    data <= d;
    link_mask <= lm;
    @(negedge clk);
    while (!gnt) @(negedge clk);
  endtask

  task automatic inject(input logic [5:0] a, input logic [CW-1:0] m);
    @(posedge clk);
    req <= 1'b0;
    fault_en <= 1'b1;
    fault_addr <= a;
    fault_mask <= m;
    @(negedge clk);
    if (gnt) begin
      $display("gnt high in a fault write cycle");
      errors++;
    end
    model_fault[a] = model_fault[a] ^ m;
    @(posedge clk);
    fault_en <= 1'b0;
  endtask

  // idle the port, wait for all responses, then check the totals
  task automatic close_test(input string name, input int err_start);
    @(posedge clk);
    req <= 1'b0;
    link_mask <= '0;
    while (exp_q.size() != 0) @(posedge clk);
    @(negedge clk);
    check_count("cnt_corrected", cnt_corrected, exp_corr);
    check_count("cnt_uncorrectable", cnt_uncorrectable, exp_unc);
    $display("test %s finished with %0d errors", name, errors - err_start);
  endtask

  initial begin : stimulus
    int             e0;
    int             c;
    int             k1;
    int             k2;
    int             n0;
    logic [5:0]     a;
    logic [CW-1:0]  m;
    logic [LW-1:0]  lm;
    seed = 32'hdc92;
    reset = 1'b1;
    {req, wen, add, be, data, fault_en, fault_addr, fault_mask} = '0;
    {link_mask, cnt_clear} = '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    e0 = errors;
    for (int i = 0; i < N_CLEAN; i++) begin
      if (i < 64) issue(1'b0, 6'(i), $random(seed), '0);  // fill every word first
      else issue(1'(rand_below(2)), 6'(rand_below(64)), $random(seed), '0);
    end
    close_test("clean traffic", e0);

    e0 = errors;
    for (int i = 0; i < N_SINGLE; i++) begin
      a = 6'(rand_below(64));
      m = '0;
      if (i % 2 == 0) m[rand_below(32)] = 1'b1;
      else m[32 + rand_below(12)] = 1'b1;  // check bits
      issue(1'b0, a, $random(seed), '0);
      inject(a, m);
      issue(1'b1, a, '0, '0);
    end
    close_test("single-bit storage fault", e0);

    e0 = errors;
    for (int i = 0; i < N_DOUBLE; i++) begin
      a = 6'(rand_below(64));
      c = rand_below(2);
      k1 = rand_below(22);
      k2 = (k1 + 1 + rand_below(21)) % 22;
      m = '0;
      m[chunk_bit(c, k1)] = 1'b1;
      m[chunk_bit(c, k2)] = 1'b1;
      issue(1'b0, a, $random(seed), '0);
      inject(a, m);
      issue(1'b1, a, '0, '0);
    end
    close_test("double-bit storage fault", e0);

    e0 = errors;
    for (int i = 0; i < N_LINK; i++) begin
      a = 6'(rand_below(64));
      issue(1'b0, a, $random(seed), '0);
      lm = '0;
      lm[rand_below(LW)] = 1'b1;
      issue(1'b0, a, $random(seed), lm);  // still lands at a
      issue(1'b1, a, '0, '0);
      k1 = rand_below(LW);
      lm = '0;
      lm[k1] = 1'b1;
      lm[(k1 + 1 + rand_below(LW - 1)) % LW] = 1'b1;
      issue(1'b0, a, $random(seed), lm);  // dropped
      issue(1'b1, a, '0, '0);
    end
    close_test("link metadata fault", e0);

    e0 = errors;
    n0 = rsp_cnt;
    a = 6'(rand_below(64));
    @(posedge clk);
    req <= 1'b1;
    wen <= 1'b1;
    add <= a;
    fault_en <= 1'b1;
    fault_addr <= a;
    fault_mask <= '0;
    @(negedge clk);
    if (gnt) begin
      $display("gnt high while fault_en is high");
      errors++;
    end
    @(posedge clk);
    fault_en <= 1'b0;
    @(negedge clk);
    while (!gnt) @(negedge clk);
    close_test("grant during fault", e0);
    if (rsp_cnt != n0 + 1) begin
      $display("expected one response for the held read, saw %0d", rsp_cnt - n0);
      errors++;
    end
    if (cnt_corrected == '0 || cnt_uncorrectable == '0) begin
      $display("counts already zero before the clear");
      errors++;
    end
    @(posedge clk);
    cnt_clear <= 1'b1;
    @(posedge clk);
    cnt_clear <= 1'b0;
    exp_corr = '0;
    exp_unc = '0;
    @(negedge clk);
    check_count("cnt_corrected", cnt_corrected, exp_corr);
    check_count("cnt_uncorrectable", cnt_uncorrectable, exp_unc);
    $display("test counter clear finished with %0d errors", errors - e0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    wait (cyc == TIMEOUT);
    $display("run did not end within %0d cycles", TIMEOUT);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== vlog.f ====
src/hci_ecc_pkg.sv
src/hsiao_ecc_enc.sv
src/hsiao_ecc_dec.sv
src/hci_ecc_enc.sv
src/tcdm_ecc_bank.sv
src/hci_ecc_err_counter.sv
src/hci_ecc_top.sv
testbench/tb_hci_ecc_top.sv
